// ==== rename_pkg.sv ====
package rename_pkg;

    localparam int RENAME_WIDTH = 2;
    localparam int COMMIT_WIDTH = 2;
    localparam int ARCH_REGS    = 8;
    localparam int PHYS_REGS    = 32;
    localparam int FREE_INIT    = PHYS_REGS - ARCH_REGS; // also the initial credit count.

    localparam int AREG_W = $clog2(ARCH_REGS);
    localparam int PREG_W = $clog2(PHYS_REGS);
    localparam int CNT_W  = PREG_W + 1;

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [PREG_W:0]   fl_ptr_t;   // top bit is the wrap bit.
    typedef logic [CNT_W-1:0]  preg_cnt_t;

    typedef struct packed {
        logic  valid;
        areg_t src1;
        areg_t src2;
        logic  has_dst;
        areg_t dst;
    } rename_req_t;

    typedef struct packed {
        logic  valid;
        preg_t psrc1;
        preg_t psrc2;
        preg_t pdst;
        preg_t old_pdst;
    } rename_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  has_dst;
        areg_t dst;
        preg_t pdst;
    } commit_t;

    typedef enum logic [1:0] {
        INIT,
        RUN,
        RECOVER
    } ctrl_state_t;

endpackage

// ==== free_list.sv ====
`timescale 1ns/10ps

module free_list (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  logic                                              map_init,
    input  logic                                              restore,
    input  rename_pkg::preg_cnt_t                             alloc_cnt,
    input  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]  release_tags,
    input  logic [rename_pkg::COMMIT_WIDTH-1:0]               release_valid,
    output rename_pkg::preg_t [rename_pkg::RENAME_WIDTH-1:0]  alloc_tags,
    output rename_pkg::preg_cnt_t                             spec_used
);
    import rename_pkg::*;

    preg_t     queue [PHYS_REGS];
    fl_ptr_t   spec_head;
    fl_ptr_t   commit_head;
    fl_ptr_t   tail;
    fl_ptr_t   commit_head_nxt;
    fl_ptr_t   wr_ptr [COMMIT_WIDTH];
    preg_cnt_t rel_cnt;
    preg_cnt_t avail;

    always_comb begin
        rel_cnt = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            rel_cnt = rel_cnt + preg_cnt_t'(release_valid[i]);
        end
    end

    // each committed destination retires one allocated tag.
    assign commit_head_nxt = commit_head + fl_ptr_t'(rel_cnt);
    assign spec_used       = preg_cnt_t'(spec_head - commit_head);
    assign avail           = preg_cnt_t'(tail - spec_head);

    always_comb begin
        fl_ptr_t rd_ptr;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            rd_ptr        = spec_head + fl_ptr_t'(i);
            alloc_tags[i] = queue[rd_ptr[PREG_W-1:0]];
        end
    end

    // freed tags are packed at the tail in lane order.
    always_comb begin
        fl_ptr_t ptr;
        ptr = tail;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            wr_ptr[i] = ptr;
            ptr       = ptr + fl_ptr_t'(release_valid[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= fl_ptr_t'(FREE_INIT);
        end else if (map_init) begin
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= fl_ptr_t'(FREE_INIT);
        end else begin
            commit_head <= commit_head_nxt;
            tail        <= tail + fl_ptr_t'(rel_cnt);
            if (restore) begin
                spec_head <= commit_head_nxt; // drop uncommitted allocations.
            end else begin
                spec_head <= spec_head + fl_ptr_t'(alloc_cnt);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (map_init) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                queue[i] <= preg_t'(i + ARCH_REGS);
            end
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (release_valid[i]) begin
                    queue[wr_ptr[i][PREG_W-1:0]] <= release_tags[i];
                end
            end
        end
    end

    // the front end must not take more tags than are free.
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_cnt <= avail)
        else $error("free list underflow: alloc %0d, free %0d.", alloc_cnt, avail);

    // commits can only return tags that were handed out earlier.
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        (avail + rel_cnt) <= (FREE_INIT + alloc_cnt))
        else $error("free list overflow: free %0d, released %0d.", avail, rel_cnt);

endmodule

// ==== rename_map.sv ====
`timescale 1ns/10ps

module rename_map (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  logic                                                  map_init,
    input  logic                                                  restore,
    input  rename_pkg::rename_req_t [rename_pkg::RENAME_WIDTH-1:0] rename_in,
    input  rename_pkg::preg_t [rename_pkg::RENAME_WIDTH-1:0]       alloc_tags,
    input  rename_pkg::preg_t [rename_pkg::ARCH_REGS-1:0]          arch_map,
    output rename_pkg::rename_rsp_t [rename_pkg::RENAME_WIDTH-1:0] rename_out,
    output rename_pkg::preg_cnt_t                                 alloc_cnt
);
    import rename_pkg::*;

    preg_t [ARCH_REGS-1:0]          map_q;
    preg_t [ARCH_REGS-1:0]          map_d;
    rename_rsp_t [RENAME_WIDTH-1:0] rsp_d;

    // lanes walk a working copy of the table in order, so a later lane
    // sees the destinations of earlier lanes and the last writer wins.
    always_comb begin
        preg_cnt_t n;
        n     = '0;
        map_d = map_q;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            rsp_d[i] = '0;
            if (rename_in[i].valid && !map_init && !restore) begin
                rsp_d[i].valid = 1'b1;
                rsp_d[i].psrc1 = map_d[rename_in[i].src1];
                rsp_d[i].psrc2 = map_d[rename_in[i].src2];
                if (rename_in[i].has_dst) begin
                    rsp_d[i].old_pdst          = map_d[rename_in[i].dst];
                    rsp_d[i].pdst              = alloc_tags[n];  // next free tag in order.
                    map_d[rename_in[i].dst]    = alloc_tags[n];
                    n                          = n + 1'b1;
                end
            end
        end
        alloc_cnt = n;
    end

    always_ff @(posedge clk) begin
        if (map_init) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_q[a] <= preg_t'(a); // identity mapping.
            end
        end else if (restore) begin
            map_q <= arch_map;
        end else begin
            map_q <= map_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rename_out <= '0;
        end else begin
            rename_out <= rsp_d; // valid bits drop while restoring.
        end
    end

endmodule

// ==== commit_map.sv ====
`timescale 1ns/10ps

module commit_map (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  logic                                              map_init,
    input  rename_pkg::commit_t [rename_pkg::COMMIT_WIDTH-1:0] commit_in,
    output rename_pkg::preg_t [rename_pkg::ARCH_REGS-1:0]     arch_map,
    output rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]  release_tags,
    output logic [rename_pkg::COMMIT_WIDTH-1:0]               release_valid
);
    import rename_pkg::*;

    preg_t [ARCH_REGS-1:0] arch_q;
    preg_t [ARCH_REGS-1:0] arch_d;

    always_comb begin
        arch_d = arch_q;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            release_tags[i]  = '0;
            release_valid[i] = 1'b0;
            if (commit_in[i].valid && commit_in[i].has_dst) begin
                release_tags[i]          = arch_d[commit_in[i].dst]; // sees earlier lanes.
                release_valid[i]         = 1'b1;
                arch_d[commit_in[i].dst] = commit_in[i].pdst;
            end
        end
    end

    // recovery copies the map including this cycle's commits.
    assign arch_map = arch_d;

    always_ff @(posedge clk) begin
        if (map_init) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                arch_q[a] <= preg_t'(a);
            end
        end else begin
            arch_q <= arch_d;
        end
    end

    // a tag being committed must not be freed by the same or an older lane.
    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : g_lane
        for (genvar j = 0; j <= i; j++) begin : g_rel
            a_no_live_release: assert property (@(posedge clk) disable iff (!arst_n)
                (commit_in[i].valid && commit_in[i].has_dst && release_valid[j])
                |-> (commit_in[i].pdst != release_tags[j]))
                else $error("committed tag %0d released in lane %0d.",
                            commit_in[i].pdst, j);
        end
    end

endmodule

// ==== rename_ctrl.sv ====
`timescale 1ns/10ps

module rename_ctrl (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  logic                                              recover,
    input  rename_pkg::commit_t [rename_pkg::COMMIT_WIDTH-1:0] commit_in,
    input  rename_pkg::preg_cnt_t                             spec_used,
    output logic                                              map_init,
    output logic                                              restore,
    output logic                                              ready,
    output rename_pkg::preg_cnt_t                             credit_ret
);
    import rename_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    preg_cnt_t   commit_cnt;
    logic        commit_any;

    always_comb begin
        commit_cnt = '0;
        commit_any = 1'b0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_any = commit_any | commit_in[i].valid;
            if (commit_in[i].valid && commit_in[i].has_dst) begin
                commit_cnt = commit_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            INIT:    state_nxt = RUN;
            RUN:     state_nxt = recover ? RECOVER : RUN;
            RECOVER: state_nxt = RUN;
            default: state_nxt = INIT;
        endcase
    end

    assign map_init = (state == INIT);
    assign restore  = (state == RECOVER);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= INIT;
            ready      <= 1'b0;
            credit_ret <= '0;
        end else begin
            state <= state_nxt;
            ready <= (state == RUN) && !recover; // one cycle behind the state.
            case (state)
                RUN:     credit_ret <= commit_cnt;
                RECOVER: credit_ret <= spec_used; // discarded allocations come back.
                default: credit_ret <= '0;
            endcase
        end
    end

    // retirement cannot start before the maps hold the identity mapping.
    a_no_commit_in_init: assert property (@(posedge clk) disable iff (!arst_n)
        (state == INIT) |-> !commit_any)
        else $error("commit during map initialisation.");

    a_recover_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        recover |=> !recover)
        else $error("recover held for more than one cycle.");

endmodule

// ==== rename_top.sv ====
`timescale 1ns/10ps

module rename_top (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  rename_pkg::rename_req_t [rename_pkg::RENAME_WIDTH-1:0] rename_in,
    input  rename_pkg::commit_t [rename_pkg::COMMIT_WIDTH-1:0]     commit_in,
    input  logic                                                  recover,
    output rename_pkg::rename_rsp_t [rename_pkg::RENAME_WIDTH-1:0] rename_out,
    output rename_pkg::preg_cnt_t                                 credit_ret,
    output logic                                                  ready
);
    import rename_pkg::*;

    logic                        map_init;
    logic                        restore;
    preg_t [RENAME_WIDTH-1:0]    alloc_tags;
    preg_cnt_t                   alloc_cnt;
    preg_t [COMMIT_WIDTH-1:0]    release_tags;
    logic [COMMIT_WIDTH-1:0]     release_valid;
    preg_t [ARCH_REGS-1:0]       arch_map;
    preg_cnt_t                   spec_used;

    rename_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .recover    (recover),
        .commit_in  (commit_in),
        .spec_used  (spec_used),
        .map_init   (map_init),
        .restore    (restore),
        .ready      (ready),
        .credit_ret (credit_ret)
    );

    free_list u_free_list (
        .clk           (clk),
        .arst_n        (arst_n),
        .map_init      (map_init),
        .restore       (restore),
        .alloc_cnt     (alloc_cnt),
        .release_tags  (release_tags),
        .release_valid (release_valid),
        .alloc_tags    (alloc_tags),
        .spec_used     (spec_used)
    );

    rename_map u_rename_map (
        .clk        (clk),
        .arst_n     (arst_n),
        .map_init   (map_init),
        .restore    (restore),
        .rename_in  (rename_in),
        .alloc_tags (alloc_tags),
        .arch_map   (arch_map),
        .rename_out (rename_out),
        .alloc_cnt  (alloc_cnt)
    );

    commit_map u_commit_map (
        .clk           (clk),
        .arst_n        (arst_n),
        .map_init      (map_init),
        .commit_in     (commit_in),
        .arch_map      (arch_map),
        .release_tags  (release_tags),
        .release_valid (release_valid)
    );

endmodule

// ==== rename_tb.sv ====
`timescale 1ns/10ps

module rename_tb;
    import rename_pkg::*;

    localparam int NUM_ROWS       = 19;
    localparam int TIMEOUT_CYCLES = 16 + 4 * NUM_ROWS + 50;

    logic                           clk = 1'b0;
    logic                           arst_n;
    rename_req_t [RENAME_WIDTH-1:0] rename_in;
    commit_t [COMMIT_WIDTH-1:0]     commit_in;
    logic                           recover;
    rename_rsp_t [RENAME_WIDTH-1:0] rename_out;
    preg_cnt_t                      credit_ret;
    logic                           ready;

    rename_req_t [RENAME_WIDTH-1:0] req_tab [NUM_ROWS];
    commit_t [COMMIT_WIDTH-1:0]     cmt_tab [NUM_ROWS];
    logic                           rec_tab [NUM_ROWS];
    rename_rsp_t [RENAME_WIDTH-1:0] rsp_tab [NUM_ROWS];
    preg_cnt_t                      cred_tab [NUM_ROWS];
    string                          name_tab [NUM_ROWS];
    int                             n_rows = 0;
    int                             credit_in = 0;    // credits handed back by the DUT.
    int                             credit_spent = 0;
    int                             cycles = 0;

    rename_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .rename_in  (rename_in),
        .commit_in  (commit_in),
        .recover    (recover),
        .rename_out (rename_out),
        .credit_ret (credit_ret),
        .ready      (ready)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    always @(negedge clk) begin
        if (credit_ret != '0) begin
            credit_in = credit_in + int'(credit_ret);
        end
    end

    function automatic rename_req_t make_req(int s1, int s2, int d);
        rename_req_t r;
        r         = '0;
        r.valid   = 1'b1;
        r.src1    = areg_t'(s1);
        r.src2    = areg_t'(s2);
        r.has_dst = 1'b1;
        r.dst     = areg_t'(d);
        return r;
    endfunction

    function automatic rename_rsp_t make_rsp(int p1, int p2, int pd, int old);
        rename_rsp_t r;
        r.valid    = 1'b1;
        r.psrc1    = preg_t'(p1);
        r.psrc2    = preg_t'(p2);
        r.pdst     = preg_t'(pd);
        r.old_pdst = preg_t'(old);
        return r;
    endfunction

    function automatic commit_t make_commit(int d, int pd);
        commit_t c;
        c.valid   = 1'b1;
        c.has_dst = 1'b1;
        c.dst     = areg_t'(d);
        c.pdst    = preg_t'(pd);
        return c;
    endfunction

    function automatic int count_dst(rename_req_t [RENAME_WIDTH-1:0] grp);
        int n;
        n = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (grp[i].valid && grp[i].has_dst) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic add_row(string name, rename_req_t q0, rename_req_t q1, commit_t c0,
                           commit_t c1, logic rec, rename_rsp_t e0, rename_rsp_t e1, int cred);
        name_tab[n_rows]   = name;
        req_tab[n_rows][0] = q0;
        req_tab[n_rows][1] = q1;
        cmt_tab[n_rows][0] = c0;
        cmt_tab[n_rows][1] = c1;
        rec_tab[n_rows]    = rec;
        rsp_tab[n_rows][0] = e0;
        rsp_tab[n_rows][1] = e1;
        cred_tab[n_rows]   = preg_cnt_t'(cred);
        n_rows++;
    endtask

    task automatic check_rsp(string name, int lane, rename_rsp_t exp, rename_rsp_t act);
        logic bad;
        bad = exp.valid ? (act !== exp) : (act.valid !== 1'b0); // idle lanes only need valid low.
        if (bad) begin
            $display("Fail %s lane %0d: expected %h, actual %h", name, lane, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_credit(string name, preg_cnt_t exp, preg_cnt_t act);
        if (act !== exp) begin
            $display("Fail %s credit_ret: expected %0d, actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_ready(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s ready: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    initial begin
        int need;
        int gap;
        arst_n    = 1'b0;
        rename_in = '0;
        commit_in = '0;
        recover   = 1'b0;
        void'($urandom(101));

        add_row("identity", make_req(1, 2, 3), make_req(4, 5, 6), '0, '0, 1'b0,
                make_rsp(1, 2, 8, 3), make_rsp(4, 5, 9, 6), 0);
        add_row("alloc_order", make_req(3, 6, 1), make_req(0, 7, 2), '0, '0, 1'b0,
                make_rsp(8, 9, 10, 1), make_rsp(0, 7, 11, 2), 0);
        add_row("bypass_src", make_req(1, 2, 4), make_req(4, 4, 5), '0, '0, 1'b0,
                make_rsp(10, 11, 12, 4), make_rsp(12, 12, 13, 5), 0);
        add_row("bypass_dst", make_req(5, 0, 7), make_req(7, 3, 7), '0, '0, 1'b0,
                make_rsp(13, 0, 14, 7), make_rsp(14, 8, 15, 14), 0);
        add_row("commit_g0", '0, '0, make_commit(3, 8), make_commit(6, 9), 1'b0, '0, '0, 2);
        add_row("commit_g1", make_req(3, 7, 0), '0, make_commit(1, 10), make_commit(2, 11),
                1'b0, make_rsp(8, 15, 16, 0), '0, 2);
        add_row("recover", '0, '0, '0, '0, 1'b1, '0, '0, 5); // tags 12 to 16 are discarded.
        add_row("recover_map", make_req(3, 1, 4), make_req(4, 5, 5), '0, '0, 1'b0,
                make_rsp(8, 10, 12, 4), make_rsp(12, 5, 13, 5), 0);
        for (int k = 0; k < 9; k++) begin
            add_row($sformatf("drain_%0d", k), make_req(0, 0, 6), make_req(0, 0, 7), '0, '0,
                    1'b0, make_rsp(0, 0, 14 + 2 * k, (k == 0) ? 9 : 12 + 2 * k),
                    make_rsp(0, 0, 15 + 2 * k, (k == 0) ? 7 : 13 + 2 * k), 0);
        end
        add_row("recycled", make_req(6, 7, 0), make_req(0, 2, 1), '0, '0, 1'b0,
                make_rsp(30, 31, 3, 0), make_rsp(3, 11, 6, 10), 0);
        add_row("commit_g7", '0, '0, make_commit(4, 12), make_commit(5, 13), 1'b0, '0, '0, 2);

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_ready("reset", 1'b0, ready);
        check_credit("reset", '0, credit_ret);
        check_rsp("reset", 0, '0, rename_out[0]);
        check_rsp("reset", 1, '0, rename_out[1]);
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        check_ready("init", 1'b0, ready);
        @(negedge clk);
        check_ready("ready_rise", 1'b1, ready); // second edge after release.

        for (int r = 0; r < NUM_ROWS; r++) begin
            while (!ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            need = count_dst(req_tab[r]);
            if (need > FREE_INIT + credit_in - credit_spent) begin
                $display("row %s needs %0d credits but the front end holds only %0d.",
                         name_tab[r], need, FREE_INIT + credit_in - credit_spent);
                stop_on_error();
            end
            credit_spent = credit_spent + need;
            rename_in <= req_tab[r];
            commit_in <= cmt_tab[r];
            recover   <= rec_tab[r];
            @(posedge clk);
            rename_in <= '0;
            commit_in <= '0;
            recover   <= 1'b0;
            @(negedge clk);
            check_rsp(name_tab[r], 0, rsp_tab[r][0], rename_out[0]);
            check_rsp(name_tab[r], 1, rsp_tab[r][1], rename_out[1]);
            if (rec_tab[r]) begin
                check_credit(name_tab[r], '0, credit_ret);
                check_ready(name_tab[r], 1'b0, ready);
                @(negedge clk);
                check_rsp(name_tab[r], 0, '0, rename_out[0]);
                check_rsp(name_tab[r], 1, '0, rename_out[1]);
                check_credit(name_tab[r], cred_tab[r], credit_ret);
                check_ready(name_tab[r], 1'b0, ready);
            end else begin
                check_credit(name_tab[r], cred_tab[r], credit_ret);
                check_ready(name_tab[r], 1'b1, ready);
            end
            gap = $urandom % 2;
            repeat (gap) @(negedge clk);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== rename_top.f ====
rename_pkg.sv
free_list.sv
rename_map.sv
commit_map.sv
rename_ctrl.sv
rename_top.sv
rename_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the rename stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module rename_tb -f rename_top.f -o rename_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
